// ==== design/mem_bus_cfg.svh ====
// Memory subsystem configuration
// RAM geometry and I/O page register address (byte addresses).

`ifndef MEM_BUS_CFG_SVH
`define MEM_BUS_CFG_SVH

// ****************************************
// RAM geometry
// ****************************************

// Depth of the RAM in 16-bit words.
`define RAM_WORDS 8192

// First byte address above the RAM (16 KB).
`define RAM_TOP 16'o040000

// ****************************************
// I/O page
// ****************************************

// Console switch register on read, display register on write.
`define CONSOLE_ADDR 16'o177570

`endif

// ==== design/mem_bus_pkg.sv ====
// Memory bus package
// Shared types for the 16-bit minicomputer memory subsystem.

package mem_bus_pkg;

   // ****************************************
   // Bus word with two views
   // ****************************************

   typedef struct packed {
      logic [7:0] hi;                  // Odd byte address.
      logic [7:0] lo;                  // Even byte address.
   } byte_lanes_t;

   typedef union packed {
      logic [15:0] word;               // Whole word view.
      byte_lanes_t lanes;              // Byte lane view.
   } bus_word_t;

   // ****************************************
   // Bus fault codes
   // ****************************************

   typedef enum logic [1:0] {
      FAULT_NONE = 2'd0,               // Access completes normally.
      FAULT_ODD  = 2'd1,               // Word access on an odd byte address.
      FAULT_NXM  = 2'd2                // Nothing answers at this address.
   } fault_t;

endpackage

// ==== design/mem_ram.sv ====
// Static RAM, 8K x 16
// Byte-lane writes on the clock edge, combinational byte-steered reads.

`timescale 1ns/10ps

`include "mem_bus_cfg.svh"

module mem_ram (
   input  logic                  CLK,
   input  logic                  sel,
   input  logic                  we,
   input  logic                  byte_op,
   input  logic [12:0]           word_addr,
   input  logic                  byte_hi,
   input  mem_bus_pkg::bus_word_t wdata,
   output mem_bus_pkg::bus_word_t rdata
);

   import mem_bus_pkg::*;

   // ****************************************
   // Storage
   // ****************************************

   logic [7:0] ram_hi [0:`RAM_WORDS-1];   // Odd bytes.
   logic [7:0] ram_lo [0:`RAM_WORDS-1];   // Even bytes.

   integer i;

   bus_word_t stored;                     // Word at word_addr.

   logic we_hi;
   logic we_lo;
   logic [7:0] wr_hi;

   // Contents start cleared in simulation and are not touched by reset.
   initial
   begin
      for (i = 0; i < `RAM_WORDS; i = i + 1)
      begin
         ram_hi[i] = 8'h00;
         ram_lo[i] = 8'h00;
      end
   end

   // ****************************************
   // Write path
   // ****************************************

   // A byte write hits one lane, a word write hits both.
   assign we_hi = sel && we && (!byte_op || byte_hi);
   assign we_lo = sel && we && (!byte_op || !byte_hi);

   // Byte data always arrives in the low lane of wdata.
   assign wr_hi = byte_op ? wdata.lanes.lo : wdata.lanes.hi;

   always_ff @(posedge CLK)
   begin
      if (we_hi)
      begin
         ram_hi[word_addr] <= wr_hi;
      end
      if (we_lo)
      begin
         ram_lo[word_addr] <= wdata.lanes.lo;
      end
   end

   // ****************************************
   // Read path
   // ****************************************

   always_comb
   begin
      stored.lanes.hi = ram_hi[word_addr];
      stored.lanes.lo = ram_lo[word_addr];
      if (byte_op)
      begin
         rdata.lanes.hi = 8'h00;                 // Zero extend.
         rdata.lanes.lo = byte_hi ? stored.lanes.hi : stored.lanes.lo;
      end
      else
      begin
         rdata = stored;
      end
   end

   // ****************************************
   // Checks
   // ****************************************

   // The bus controller must never select the RAM on a floating address.
   a_sel_addr_known : assert property (
      @(posedge CLK) sel |-> !$isunknown(word_addr)
   ) else $error("RAM selected with unknown word address.");

   // Odd word accesses are faulted upstream and never reach the RAM.
   a_no_odd_word : assert property (
      @(posedge CLK) sel |-> (byte_op || !byte_hi)
   ) else $error("RAM selected for a word access on an odd address.");

endmodule

// ==== design/io_page_regs.sv ====
// Console registers on the I/O page
// Reads return the switch register. Writes load the display register.

`timescale 1ns/10ps

module io_page_regs (
   input  logic                  CLK,
   input  logic                  reset,
   input  logic                  sel,
   input  logic                  we,
   input  logic                  byte_op,
   input  logic                  byte_hi,
   input  mem_bus_pkg::bus_word_t wdata,
   input  logic [15:0]           switches,
   output mem_bus_pkg::bus_word_t rdata,
   output logic [15:0]           display
);

   import mem_bus_pkg::*;

   bus_word_t disp_q;                     // Display register.
   bus_word_t sw;                         // Switches as a bus word.

   // ****************************************
   // Switch register read
   // ****************************************

   assign sw.word = switches;

   always_comb
   begin
      if (byte_op)
      begin
         rdata.lanes.hi = 8'h00;
         rdata.lanes.lo = byte_hi ? sw.lanes.hi : sw.lanes.lo;
      end
      else
      begin
         rdata = sw;
      end
   end

   // ****************************************
   // Display register write
   // ****************************************

   always_ff @(posedge CLK)
   begin
      if (reset)
      begin
         disp_q.word <= 16'h0000;
      end
      else if (sel && we)
      begin
         if (!byte_op)
            disp_q <= wdata;                      // Whole word.
         else if (byte_hi)
            disp_q.lanes.hi <= wdata.lanes.lo;    // Odd byte.
         else
            disp_q.lanes.lo <= wdata.lanes.lo;    // Even byte.
      end
   end

   assign display = disp_q.word;

endmodule

// ==== design/mem_bus_ctl.sv ====
// Memory bus controller
// Decodes each access into RAM, I/O page or a fault, drives the device
// selects and picks the read data.

`timescale 1ns/10ps

`include "mem_bus_cfg.svh"

module mem_bus_ctl (
   input  logic                  [15:0] addr,
   input  logic                         cyc,
   input  logic                         byte_op,
   input  mem_bus_pkg::bus_word_t       ram_rdata,
   input  mem_bus_pkg::bus_word_t       io_rdata,
   output logic                         ram_sel,
   output logic                         io_sel,
   output mem_bus_pkg::fault_t          fault,
   output logic                  [15:0] rdata
);

   import mem_bus_pkg::*;

   localparam logic [15:0] RAM_TOP      = `RAM_TOP;
   localparam logic [15:0] CONSOLE_ADDR = `CONSOLE_ADDR;

   logic odd_word;                        // Word access on odd address.
   logic in_ram;                          // Address below the RAM top.
   logic in_console;                      // Either byte of the console register.

   // ****************************************
   // Address decode
   // ****************************************

   assign odd_word   = !byte_op && addr[0];
   assign in_ram     = addr < RAM_TOP;
   assign in_console = (addr == CONSOLE_ADDR) || (addr == CONSOLE_ADDR + 16'd1);

   always_comb
   begin
      ram_sel = 1'b0;
      io_sel  = 1'b0;
      fault   = FAULT_NONE;
      if (cyc)
      begin
         // Odd word check wins over the address map.
         if (odd_word)
            fault = FAULT_ODD;
         else if (in_ram)
            ram_sel = 1'b1;
         else if (in_console)
            io_sel = 1'b1;
         else
            fault = FAULT_NXM;
      end

      // Selects are exclusive and both drop on any fault.
      a_sel_onehot : assert ($onehot0({ram_sel, io_sel}))
         else $error("RAM and I/O page selected together.");
      a_sel_fault : assert (fault == FAULT_NONE || !(ram_sel || io_sel))
         else $error("Device selected during a bus fault.");
   end

   // ****************************************
   // Read data multiplexer
   // ****************************************

   always_comb
   begin
      if (ram_sel)
         rdata = ram_rdata.word;
      else if (io_sel)
         rdata = io_rdata.word;
      else
         rdata = 16'h0000;               // Idle bus or fault.
   end

endmodule

// ==== design/mem_subsys_top.sv ====
// Memory subsystem top level
// Bus controller, 16 KB RAM and the console registers on the I/O page.

`timescale 1ns/10ps

module mem_subsys_top (
   input  logic                      CLK,
   input  logic                      reset,
   input  logic               [15:0] addr,
   input  logic               [15:0] wdata,
   input  logic                      cyc,
   input  logic                      we,
   input  logic                      byte_op,
   input  logic               [15:0] switches,
   output logic               [15:0] rdata,
   output mem_bus_pkg::fault_t       fault,
   output logic               [15:0] display
);

   import mem_bus_pkg::*;

   logic      ram_sel;
   logic      io_sel;
   bus_word_t ram_rdata;
   bus_word_t io_rdata;

   mem_bus_ctl u_ctl (
      .addr      (addr),
      .cyc       (cyc),
      .byte_op   (byte_op),
      .ram_rdata (ram_rdata),
      .io_rdata  (io_rdata),
      .ram_sel   (ram_sel),
      .io_sel    (io_sel),
      .fault     (fault),
      .rdata     (rdata)
   );

   // Word address and byte lane come straight off the bus.
   mem_ram u_ram (
      .CLK       (CLK),
      .sel       (ram_sel),
      .we        (we),
      .byte_op   (byte_op),
      .word_addr (addr[13:1]),
      .byte_hi   (addr[0]),
      .wdata     (wdata),
      .rdata     (ram_rdata)
   );

   io_page_regs u_io (
      .CLK       (CLK),
      .reset     (reset),
      .sel       (io_sel),
      .we        (we),
      .byte_op   (byte_op),
      .byte_hi   (addr[0]),
      .wdata     (wdata),
      .switches  (switches),
      .rdata     (io_rdata),
      .display   (display)
   );

endmodule

// ==== testbench/tb_mem_subsys.sv ====
// Testbench for the memory subsystem
// Random RAM, fault and console traffic checked against a byte-wide shadow model.

`timescale 1ns/10ps

`include "mem_bus_cfg.svh"

module tb_mem_subsys;

   import mem_bus_pkg::*;

   localparam int N_WORD  = 64;
   localparam int N_BYTE  = 32;
   localparam int N_ODD   = 16;
   localparam int N_NXM   = 16;
   localparam int N_CONS  = 16;
   localparam int N_IDLE  = 8;
   localparam int NUM_OPS = 2 * N_WORD + 3 * N_BYTE + 3 * N_ODD + 2 * N_NXM
                            + 4 * N_CONS + N_IDLE + 16;   // Plus reset and tail cycles.

   logic        CLK = 1'b0;
   logic        reset;
   logic [15:0] addr;
   logic [15:0] wdata;
   logic        cyc;
   logic        we;
   logic        byte_op;
   logic [15:0] switches;
   logic [15:0] rdata;
   fault_t      fault;
   logic [15:0] display;

   integer      seed = 32'h80720cfa;
   logic        checking = 1'b0;              // Compare enabled after reset.
   logic [15:0] sw_next = 16'h0000;           // Switches for the next access.
   logic [7:0]  shadow [0:2*`RAM_WORDS-1];    // Expected RAM, one byte per entry.
   bus_word_t   disp_model;                   // Expected display register.
   logic [15:0] word_addrs [0:N_WORD-1];

   mem_subsys_top DUT (
      .CLK      (CLK),
      .reset    (reset),
      .addr     (addr),
      .wdata    (wdata),
      .cyc      (cyc),
      .we       (we),
      .byte_op  (byte_op),
      .switches (switches),
      .rdata    (rdata),
      .fault    (fault),
      .display  (display)
   );

   always #2 CLK = ~CLK;

   // ****************************************
   // Reference model
   // ****************************************

   // Returns {fault, rdata} for one access against the shadow state.
   function automatic logic [17:0] expected_read(input logic [15:0] a, input logic bop,
                                                 input logic c, input logic [15:0] sw);
      fault_t      f;
      logic [15:0] d;
      f = FAULT_NONE;
      d = 16'h0000;
      if (c)
      begin
         if (!bop && a[0])
            f = FAULT_ODD;                      // Odd word access.
         else if (a < `RAM_TOP)
         begin
            if (bop)
               d = {8'h00, shadow[a[13:0]]};
            else
               d = {shadow[{a[13:1], 1'b1}], shadow[{a[13:1], 1'b0}]};
         end
         else if (a == `CONSOLE_ADDR || a == `CONSOLE_ADDR + 16'd1)
         begin
            if (!bop)
               d = sw;
            else
               d = a[0] ? {8'h00, sw[15:8]} : {8'h00, sw[7:0]};
         end
         else
            f = FAULT_NXM;                      // Nothing answers.
      end
      return {f, d};
   endfunction

   // Applies a good write to the shadow state.
   task automatic update_model(input logic [15:0] a, input logic bop, input logic [15:0] d);
      bus_word_t wd;
      wd.word = d;
      if (a < `RAM_TOP)
      begin
         if (bop)
            shadow[a[13:0]] = wd.lanes.lo;
         else
         begin
            shadow[{a[13:1], 1'b0}] = wd.lanes.lo;
            shadow[{a[13:1], 1'b1}] = wd.lanes.hi;
         end
      end
      else if (!bop)
         disp_model = wd;
      else if (a[0])
         disp_model.lanes.hi = wd.lanes.lo;     // Byte data rides the low lane.
      else
         disp_model.lanes.lo = wd.lanes.lo;
   endtask

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      if (got !== exp)
      begin
         $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         $display("Checks failed");
         $fatal(1, "Mismatch on %s.", name);
      end
   endtask

   // One bus access per cycle, launched on the falling edge.
   task automatic drive_access(input logic c, input logic w, input logic b,
                               input logic [15:0] a, input logic [15:0] d);
      @(negedge CLK);
      cyc      = c;
      we       = w;
      byte_op  = b;
      addr     = a;
      wdata    = d;
      switches = sw_next;
   endtask

   // ****************************************
   // Compare process
   // ****************************************

   initial
   begin : compare
      logic [17:0] exp;
      forever
      begin
         @(negedge CLK);
         #1.5;                                  // Just before the rising edge.
         if (checking)
         begin
            exp = expected_read(addr, byte_op, cyc, switches);
            check_value("rdata", rdata, exp[15:0]);
            check_value("fault", {14'd0, fault}, {14'd0, exp[17:16]});
            check_value("display", display, disp_model.word);
            if (reset)
               disp_model.word = 16'h0000;
            else if (cyc && we && exp[17:16] == FAULT_NONE)
               update_model(addr, byte_op, wdata);
         end
      end
   end

   // Watchdog.
   initial
   begin
      #(NUM_OPS * 4 * 2);
      $display("Timeout: the stimulus did not finish in the expected time.");
      $display("Checks failed");
      $fatal(1, "Watchdog expired.");
   end

   // ****************************************
   // Stimulus
   // ****************************************

   initial
   begin : stimulus
      logic [31:0] r;
      logic [15:0] a;
      integer      k;
      reset    = 1'b1;
      cyc      = 1'b0;
      we       = 1'b0;
      byte_op  = 1'b0;
      addr     = 16'h0000;
      wdata    = 16'h0000;
      switches = 16'h0000;
      disp_model.word = 16'h0000;
      for (k = 0; k < 2 * `RAM_WORDS; k = k + 1)
         shadow[k] = 8'h00;                     // RAM starts cleared.
      repeat (2) @(negedge CLK);
      reset    = 1'b0;
      checking = 1'b1;

      // Word writes, then word reads of the same even addresses.
      for (k = 0; k < N_WORD; k = k + 1)
      begin
         r = $random(seed);
         word_addrs[k] = r[15:0] & 16'h3ffe;
         drive_access(1'b1, 1'b1, 1'b0, word_addrs[k], r[31:16]);
      end
      for (k = 0; k < N_WORD; k = k + 1)
         drive_access(1'b1, 1'b0, 1'b0, word_addrs[k], 16'h0000);

      // Byte write, byte read back, word read of both lanes.
      for (k = 0; k < N_BYTE; k = k + 1)
      begin
         r = $random(seed);
         a = r[15:0] & 16'h3fff;
         drive_access(1'b1, 1'b1, 1'b1, a, r[31:16]);
         drive_access(1'b1, 1'b0, 1'b1, a, 16'h0000);
         drive_access(1'b1, 1'b0, 1'b0, a & 16'hfffe, 16'h0000);
      end

      // Odd word write must fault and leave the word alone.
      for (k = 0; k < N_ODD; k = k + 1)
      begin
         r = $random(seed);
         a = (r[15:0] & 16'h3fff) | 16'h0001;
         drive_access(1'b1, 1'b1, 1'b0, a & 16'hfffe, r[31:16]);
         drive_access(1'b1, 1'b1, 1'b0, a, ~r[31:16]);
         drive_access(1'b1, 1'b0, 1'b0, a & 16'hfffe, 16'h0000);
      end

      // Nonexistent memory, then a read of the RAM alias.
      for (k = 0; k < N_NXM; k = k + 1)
      begin
         r = $random(seed);
         a = r[15:0] | 16'h4000;
         if (!r[16])
            a[0] = 1'b0;                        // Keep word accesses even.
         if ((a & 16'hfffe) == `CONSOLE_ADDR)
            a = a ^ 16'h0100;
         drive_access(1'b1, 1'b1, r[16], a, r[31:16]);
         drive_access(1'b1, 1'b0, 1'b0, a & 16'h3ffe, 16'h0000);
      end

      // Console switch reads and display writes.
      for (k = 0; k < N_CONS; k = k + 1)
      begin
         r = $random(seed);
         sw_next = r[15:0];
         drive_access(1'b1, 1'b0, 1'b0, `CONSOLE_ADDR, 16'h0000);
         drive_access(1'b1, 1'b0, 1'b1, `CONSOLE_ADDR, 16'h0000);
         drive_access(1'b1, 1'b0, 1'b1, `CONSOLE_ADDR + 16'd1, 16'h0000);
         a = `CONSOLE_ADDR;
         if (r[16] && r[17])
            a = a + 16'd1;                      // Odd byte lane.
         drive_access(1'b1, 1'b1, r[16], a, r[31:16]);
      end

      // Idle bus with random levels on the other inputs.
      for (k = 0; k < N_IDLE; k = k + 1)
      begin
         r = $random(seed);
         a = r[18] ? `CONSOLE_ADDR : r[15:0];
         drive_access(1'b0, r[16], r[17], a, r[31:16]);
      end

      // Second reset clears the display.
      @(negedge CLK);
      reset = 1'b1;
      cyc   = 1'b0;
      we    = 1'b0;
      repeat (2) @(negedge CLK);
      reset = 1'b0;
      drive_access(1'b1, 1'b0, 1'b1, `CONSOLE_ADDR, 16'h0000);
      drive_access(1'b0, 1'b0, 1'b0, 16'h0000, 16'h0000);
      @(negedge CLK);
      #2;
      $display("All checks passed");
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+design
design/mem_bus_pkg.sv
design/mem_ram.sv
design/io_page_regs.sv
design/mem_bus_ctl.sv
design/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the memory subsystem testbench with Verilator and run it.
# The run passes only if the pass message shows up in the simulation output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_mem_subsys \
   -f sim.f \
   -o tb_mem_subsys \
   && ./obj_dir/tb_mem_subsys | tee /dev/stderr | grep -q "All checks passed" \
   && echo "Simulation PASSED" \
   || { echo "Simulation FAILED"; exit 1; }
